//--- sceneChange.f
src/geomPkg.sv
src/pixelPkg.sv
src/spriteBoxIf.sv
src/spriteMotion.sv
src/spriteDotGen.sv
src/checkerBgGen.sv
src/layerFifo.sv
src/sceneChange.sv
dv/sceneChange_sva.sv
dv/sceneChangeTb.sv

//--- dv/sceneChangeTb.sv
// sceneChangeTb: clock, reset, seeded stimulus, sprite and FIFO model, compare tasks, watchdog
`timescale 1ns/1ns

module sceneChangeTb;

	// --------------------------------------------------------------------------
	// run length
	// --------------------------------------------------------------------------
	localparam int clkPeriod   = 8;
	localparam int resetCycles = 5;
	localparam int firstCycles = 40;	// raster over the start box
	localparam int mergeCycles = 400;
	localparam int frameCount  = 400;
	localparam int maxGap      = 6;		// pixel cycles between frame ends
	localparam int fillCycles  = 48;
	localparam int drainCycles = 32;
	localparam int totalCycles = resetCycles + firstCycles + mergeCycles
		+ frameCount * (maxGap + 1) + fillCycles + drainCycles + 200;	// 200 spare
	localparam int hDisp       = 64;	// small screen, walls come fast
	localparam int vDisp       = 48;

	logic                       iClk;
	logic                       rstN;
	pixelPkg::pixelT            iColor;
	logic [geomPkg::hWidth-1:0] iHdisplay;
	logic [geomPkg::vWidth-1:0] iVdisplay;
	logic [geomPkg::hWidth-1:0] iHpos;
	logic [geomPkg::vWidth-1:0] iVpos;
	logic                       iFe;
	logic                       iEds;
	logic                       iEdd;
	logic                       oFull;
	logic                       oEmp;
	logic                       oVdd;
	pixelPkg::pixelT            oDd;

	// model state
	int              mLeft;
	int              mTop;
	bit              mDirRight;
	bit              mDirUp;		// top edge decreasing
	int              mCount;		// FIFO occupancy
	pixelPkg::pixelT mQueue [$];	// words held, oldest first
	pixelPkg::pixelT mMerged;		// layer regs after merge
	logic            mEdsDly;
	logic            expVdd;
	pixelPkg::pixelT expDd;
	int              hitRight;
	int              hitLeft;
	int              hitTop;
	int              hitFloor;
	int              mismatches;
	int              failures;
	integer          seed;

	sceneChange i_dut
	(
		.iClk      (iClk),
		.rstN      (rstN),
		.iColor    (iColor),
		.iHdisplay (iHdisplay),
		.iVdisplay (iVdisplay),
		.iHpos     (iHpos),
		.iVpos     (iVpos),
		.iFe       (iFe),
		.iEds      (iEds),
		.iEdd      (iEdd),
		.oFull     (oFull),
		.oEmp      (oEmp),
		.oVdd      (oVdd),
		.oDd       (oDd)
	);

	initial
	begin
		iClk = 1'b0;
		forever #(clkPeriod / 2) iClk = ~iClk;
	end

	// --------------------------------------------------------------------------
	// random helpers
	// --------------------------------------------------------------------------
	function automatic int randRange(int lo, int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	function automatic logic coin(int pct);
		return randRange(0, 99) < pct;
	endfunction

	// raster coordinate near a box edge, never negative
	function automatic int nearEdge(int edgePos);
		return randRange((edgePos > 4) ? edgePos - 4 : 0, edgePos + geomPkg::spriteSize + 4);
	endfunction

	// --------------------------------------------------------------------------
	// reference model
	// --------------------------------------------------------------------------
	function automatic pixelPkg::pixelT expectPixel(int h, int v, pixelPkg::pixelT col);
		bit hit;
		bit oddTile;
		hit = (h >= mLeft) && (h <= mLeft + geomPkg::spriteSize)
			&& (v >= mTop) && (v <= mTop + geomPkg::spriteSize);
		oddTile = ((h >> pixelPkg::checkerShift) ^ (v >> pixelPkg::checkerShift)) & 1;
		if (hit)
			return col;
		return oddTile ? pixelPkg::bgColorB : pixelPkg::bgColorA;
	endfunction

	// one frame step with wall clamp and turn
	task automatic stepBox();
		int nx;
		int ny;
		if (mDirRight)
		begin
			nx = mLeft + geomPkg::stepX;
			if (nx + geomPkg::spriteSize > hDisp - 1)
			begin
				nx        = hDisp - 1 - geomPkg::spriteSize;
				mDirRight = 1'b0;
				hitRight++;
			end
		end
		else
		begin
			nx = mLeft - geomPkg::stepX;
			if (nx < 0)
			begin
				nx        = 0;
				mDirRight = 1'b1;
				hitLeft++;
			end
		end
		if (mDirUp)
		begin
			ny = mTop - geomPkg::stepY;
			if (ny < 0)
			begin
				ny     = 0;
				mDirUp = 1'b0;
				hitTop++;
			end
		end
		else
		begin
			ny = mTop + geomPkg::stepY;
			if (ny + geomPkg::spriteSize > vDisp - 1)
			begin
				ny     = vDisp - 1 - geomPkg::spriteSize;
				mDirUp = 1'b1;
				hitFloor++;
			end
		end
		mLeft = nx;
		mTop  = ny;
	endtask

	// what the design does at one rising edge, from the inputs seen there
	task automatic modelEdge();
		bit wr;
		bit rd;
		wr     = mEdsDly && (mCount < pixelPkg::fifoDepth);	// full drops it
		rd     = iEdd && (mCount > 0);
		expVdd = rd;
		if (rd)
			expDd = mQueue.pop_front();
		if (wr)
			mQueue.push_back(mMerged);
		mCount  = mCount + int'(wr) - int'(rd);
		mMerged = expectPixel(iHpos, iVpos, iColor);	// box before this frame step
		mEdsDly = iEds;
		if (iFe)
			stepBox();
	endtask

	// --------------------------------------------------------------------------
	// compare tasks
	// --------------------------------------------------------------------------
	task automatic checkPixel(string name, pixelPkg::pixelT actual, pixelPkg::pixelT expected);
		if (actual !== expected)
		begin
			mismatches++;
			$display("MISMATCH %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic checkFlag(string name, logic actual, logic expected);
		if (actual !== expected)
		begin
			mismatches++;
			$display("MISMATCH %s: got %h, expected %h at %0t", name, actual, expected, $time);
		end
	endtask

	task automatic checkOutputs();
		if (oVdd === 1'b1 && !expVdd && mQueue.size() == 0)
		begin
			failures++;
			$display("ERROR: oVdd pulse while the model FIFO is empty at %0t", $time);
		end
		else
			checkFlag("oVdd", oVdd, expVdd);
		if (oVdd === 1'b1 && expVdd)
			checkPixel("oDd", oDd, expDd);
		checkFlag("oFull", oFull, mCount == pixelPkg::fifoDepth);
		checkFlag("oEmp", oEmp, mCount == 0);
	endtask

	// model at the edge, drive next inputs, check at the falling edge
	task automatic runCycle(input logic fe, input logic eds, input logic edd, input int h,
		input int v);
		@(posedge iClk);
		modelEdge();
		iFe    <= fe;
		iEds   <= eds;
		iEdd   <= edd;
		iHpos  <= (geomPkg::hWidth)'(h);
		iVpos  <= (geomPkg::vWidth)'(v);
		iColor <= pixelPkg::pixelT'($random(seed));
		@(negedge iClk);
		checkOutputs();
	endtask

	task automatic reportCounts();
		int svaFails;
		svaFails = i_dut.uFifo.fifoChecks.assertFails + i_dut.uMotion.boxChecks.assertFails;
		$display("error counts: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, failures, svaFails);
	endtask

	// --------------------------------------------------------------------------
	// test sequence
	// --------------------------------------------------------------------------
	initial
	begin
		int guard;
		int svaFails;
		seed      = 32'h491672ed;
		rstN      = 1'b0;
		iColor    = '0;
		iHdisplay = (geomPkg::hWidth)'(hDisp);
		iVdisplay = (geomPkg::vWidth)'(vDisp);
		iHpos     = '0;
		iVpos     = '0;
		iFe       = 1'b0;
		iEds      = 1'b0;
		iEdd      = 1'b0;
		mLeft     = geomPkg::initX;
		mTop      = geomPkg::initY;
		mDirRight = 1'b1;
		mDirUp    = 1'b1;
		mCount    = 0;
		mMerged   = pixelPkg::bgColorA;
		mEdsDly   = 1'b0;
		expVdd    = 1'b0;
		expDd     = '0;
		repeat (resetCycles) @(posedge iClk);
		rstN <= 1'b1;
		@(negedge iClk);
		checkOutputs();	// empty, not full, no valid

		// start box, top edge below the small screen
		repeat (firstCycles)
			runCycle(1'b0, 1'b1, coin(60), randRange(0, hDisp - 1), nearEdge(geomPkg::initY));

		// layer merge, both layers reachable
		repeat (mergeCycles)
			runCycle(1'b0, coin(50), coin(50), randRange(0, hDisp - 1), randRange(0, 280));

		// motion and bounce, single-cycle frame ends with random gaps
		for (int f = 0; f < frameCount; f++)
		begin
			runCycle(1'b1, coin(50), coin(50), nearEdge(mLeft), nearEdge(mTop));
			repeat (randRange(1, maxGap))
				runCycle(1'b0, coin(70), coin(50), nearEdge(mLeft), nearEdge(mTop));
		end
		if (hitRight == 0 || hitLeft == 0 || hitTop == 0 || hitFloor == 0)
		begin
			failures++;
			$display("ERROR: sprite did not bounce off every wall (r %0d, l %0d, t %0d, b %0d)",
				hitRight, hitLeft, hitTop, hitFloor);
		end

		// back-pressure, source backs off on full
		repeat (fillCycles)
			runCycle(1'b0, mCount != pixelPkg::fifoDepth, 1'b0, randRange(0, hDisp - 1),
				randRange(0, vDisp - 1));
		if (mCount != pixelPkg::fifoDepth)
		begin
			failures++;
			$display("ERROR: FIFO never filled during the write burst");
		end

		// drain until empty, then no more valid pulses
		guard = 0;
		while (oEmp !== 1'b1 && guard < drainCycles)
		begin
			runCycle(1'b0, 1'b0, 1'b1, 0, 0);
			guard++;
		end
		if (oEmp !== 1'b1)
		begin
			failures++;
			$display("ERROR: FIFO did not drain within %0d reads", drainCycles);
		end
		repeat (4)
			runCycle(1'b0, 1'b0, 1'b1, 0, 0);

		svaFails = i_dut.uFifo.fifoChecks.assertFails + i_dut.uMotion.boxChecks.assertFails;
		reportCounts();
		if (mismatches + failures + svaFails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog over the whole run
	initial
	begin
		#(totalCycles * clkPeriod);
		$display("ERROR: watchdog expired after %0d cycles", totalCycles);
		reportCounts();
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- dv/sceneChange_sva.sv
// bound checks on FIFO flags, read valid timing and sprite box ordering
`timescale 1ns/1ns

module sceneChangeSva
#(
	parameter bit fifoSide = 1'b1	// set in the layerFifo copy, clear in the spriteMotion copy
)
(
	input logic                     iClk,
	input logic                     rstN,
	input logic                     full,
	input logic                     emp,
	input logic                     vdd,
	input logic                     rdEn,	// accepted read this cycle
	input logic [geomPkg::hWidth:0] leftX,
	input logic [geomPkg::hWidth:0] rightX,
	input logic [geomPkg::vWidth:0] topY,
	input logic [geomPkg::vWidth:0] underY
);

	int assertFails = 0;	// failed assertion tally

	generate
		if (fifoSide)
		begin : gFifo
			// full and empty never together
			flagsExclusive: assert property (@(posedge iClk) disable iff (!rstN) !(full && emp))
				else
				begin
					assertFails++;
					$error("oFull and oEmp high together");
				end

			// valid only after an accepted read
			validNeedsRead: assert property (@(posedge iClk) disable iff (!rstN) !rdEn |=> !vdd)
				else
				begin
					assertFails++;
					$error("oVdd pulse after a cycle without a read");
				end
		end
		else
		begin : gBox
			// near edges never past far edges
			boxOrdered: assert property (@(posedge iClk) disable iff (!rstN)
				(leftX <= rightX) && (topY <= underY))
				else
				begin
					assertFails++;
					$error("sprite box edges out of order");
				end
		end
	endgenerate

endmodule

// ---------------------------------------------------------------------------
// attach points
// ---------------------------------------------------------------------------
bind layerFifo sceneChangeSva #(.fifoSide(1'b1)) fifoChecks
(
	.iClk   (iClk),
	.rstN   (rstN),
	.full   (oFull),
	.emp    (oEmp),
	.vdd    (oVdd),
	.rdEn   (rdEn),
	.leftX  ('0),
	.rightX ('0),
	.topY   ('0),
	.underY ('0)
);

bind spriteMotion sceneChangeSva #(.fifoSide(1'b0)) boxChecks
(
	.iClk   (iClk),
	.rstN   (rstN),
	.full   (1'b0),
	.emp    (1'b1),
	.vdd    (1'b0),
	.rdEn   (1'b0),
	.leftX  (box.leftX),
	.rightX (box.rightX),
	.topY   (box.topY),
	.underY (box.underY)
);

//--- src/sceneChange.sv
// sceneChange: bouncing sprite over checkerboard, merged pixels out through a FIFO
`timescale 1ns/1ns

module sceneChange
(
	input  logic                       iClk,
	input  logic                       rstN,
	input  pixelPkg::pixelT            iColor,		// sprite colour
	input  logic [geomPkg::hWidth-1:0] iHdisplay,	// screen width
	input  logic [geomPkg::vWidth-1:0] iVdisplay,	// screen height
	input  logic [geomPkg::hWidth-1:0] iHpos,		// raster x
	input  logic [geomPkg::vWidth-1:0] iVpos,		// raster y
	input  logic                       iFe,			// frame end pulse
	input  logic                       iEds,		// source write enable
	input  logic                       iEdd,		// dest read enable
	output logic                       oFull,
	output logic                       oEmp,
	output logic                       oVdd,
	output pixelPkg::pixelT            oDd
);

	pixelPkg::pixelT sprPixel;
	logic            sprHit;
	pixelPkg::pixelT bgPixel;

	spriteBoxIf boxIf ();	// sprite edges, motion to dot gen

	// --------------------------------------------------------------------------
	// sprite layer
	// --------------------------------------------------------------------------
	spriteMotion uMotion
	(
		.iClk      (iClk),
		.rstN      (rstN),
		.iHdisplay (iHdisplay),
		.iVdisplay (iVdisplay),
		.iFe       (iFe),
		.box       (boxIf.motion)
	);

	spriteDotGen uSprite
	(
		.iClk     (iClk),
		.rstN     (rstN),
		.iColor   (iColor),
		.iHpos    (iHpos),
		.iVpos    (iVpos),
		.box      (boxIf.box),
		.sprPixel (sprPixel),
		.sprHit   (sprHit)
	);

	// background layer, runs beside the sprite path
	checkerBgGen uChecker
	(
		.iClk    (iClk),
		.rstN    (rstN),
		.iHpos   (iHpos),
		.iVpos   (iVpos),
		.bgPixel (bgPixel)
	);

	// --------------------------------------------------------------------------
	// merge and buffer
	// --------------------------------------------------------------------------
	layerFifo uFifo
	(
		.iClk     (iClk),
		.rstN     (rstN),
		.sprPixel (sprPixel),
		.sprHit   (sprHit),
		.bgPixel  (bgPixel),
		.iEds     (iEds),
		.iEdd     (iEdd),
		.oFull    (oFull),
		.oEmp     (oEmp),
		.oVdd     (oVdd),
		.oDd      (oDd)
	);

endmodule

//--- src/layerFifo.sv
// layerFifo: sprite over background merge and output FIFO with full and empty flags
`timescale 1ns/1ns

module layerFifo
(
	input  logic            iClk,
	input  logic            rstN,
	input  pixelPkg::pixelT sprPixel,	// sprite layer
	input  logic            sprHit,		// sprite covers this pixel
	input  pixelPkg::pixelT bgPixel,	// background layer
	input  logic            iEds,		// source write enable
	input  logic            iEdd,		// dest read enable
	output logic            oFull,
	output logic            oEmp,
	output logic            oVdd,		// read data valid, one pulse per word
	output pixelPkg::pixelT oDd			// read data
);

	logic                                 edsDly;	// iEds aligned with layer regs
	pixelPkg::pixelT                      merged;	// top layer wins
	logic                                 wrEn;
	logic                                 rdEn;
	logic [pixelPkg::fifoAddrWidth-1:0]   wrPtr;
	logic [pixelPkg::fifoAddrWidth-1:0]   rdPtr;
	logic [pixelPkg::fifoAddrWidth:0]     count;	// words held, 0..fifoDepth

	pixelPkg::pixelT mem [pixelPkg::fifoDepth];

	// --------------------------------------------------------------------------
	// write side
	// --------------------------------------------------------------------------
	// layers lag the raster by one cycle
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			edsDly <= 1'b0;
		else
			edsDly <= iEds;
	end

	assign merged = sprHit ? sprPixel : bgPixel;
	assign wrEn   = edsDly && !oFull;	// a write while full is lost
	assign rdEn   = iEdd && !oEmp;

	// flags straight off the occupancy count
	assign oFull = count == (pixelPkg::fifoAddrWidth+1)'(pixelPkg::fifoDepth);
	assign oEmp  = count == '0;

	always_ff @(posedge iClk)
	begin
		if (wrEn)
			mem[wrPtr] <= merged;
	end

	// --------------------------------------------------------------------------
	// pointers and occupancy
	// --------------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;	// wraps at the power of two depth
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
			case ({wrEn, rdEn})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// both or neither
			endcase
		end
	end

	// --------------------------------------------------------------------------
	// read side, data and valid one cycle after the read
	// --------------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			oVdd <= 1'b0;
		else
			oVdd <= rdEn;
	end

	always_ff @(posedge iClk)
	begin
		if (rdEn)
			oDd <= mem[rdPtr];
	end

endmodule

//--- src/checkerBgGen.sv
// checkerBgGen: registered checkerboard background pixel from raster position
`timescale 1ns/1ns

module checkerBgGen
(
	input  logic                       iClk,
	input  logic                       rstN,
	input  logic [geomPkg::hWidth-1:0] iHpos,	// raster x
	input  logic [geomPkg::vWidth-1:0] iVpos,	// raster y
	output pixelPkg::pixelT            bgPixel	// background layer
);

	logic tileX;	// tile column parity
	logic tileY;	// tile row parity
	logic tileB;	// odd tile, second colour

	// tile parity from the bit just above the in-tile offset
	assign tileX = iHpos[pixelPkg::checkerShift];
	assign tileY = iVpos[pixelPkg::checkerShift];
	assign tileB = tileX ^ tileY;

	// --------------------------------------------------------------------------
	// one register stage, same latency as the sprite test
	// --------------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			bgPixel <= pixelPkg::bgColorA;
		else if (tileB)
			bgPixel <= pixelPkg::bgColorB;
		else
			bgPixel <= pixelPkg::bgColorA;
	end

endmodule

//--- src/spriteDotGen.sv
// spriteDotGen: registered raster-in-box test, sprite pixel and hit flag
`timescale 1ns/1ns

module spriteDotGen
(
	input  logic                       iClk,
	input  logic                       rstN,
	input  pixelPkg::pixelT            iColor,	// sprite fill colour
	input  logic [geomPkg::hWidth-1:0] iHpos,	// raster x
	input  logic [geomPkg::vWidth-1:0] iVpos,	// raster y
	spriteBoxIf.box                    box,
	output pixelPkg::pixelT            sprPixel,
	output logic                       sprHit	// pixel inside the box
);

	logic [geomPkg::hWidth:0] hpos;	// raster x widened to edge width
	logic [geomPkg::vWidth:0] vpos;
	logic                     inX;
	logic                     inY;

	assign hpos = {1'b0, iHpos};
	assign vpos = {1'b0, iVpos};

	// edges are inclusive on both sides
	assign inX = (box.leftX <= hpos) && (hpos <= box.rightX);
	assign inY = (box.topY <= vpos) && (vpos <= box.underY);

	// --------------------------------------------------------------------------
	// one register stage, lines up with the checker layer
	// --------------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
			sprHit <= 1'b0;
		else
			sprHit <= inX && inY;
	end

	// colour word just rides along
	always_ff @(posedge iClk)
	begin
		sprPixel <= iColor;
	end

endmodule

//--- src/spriteMotion.sv
// spriteMotion: sprite position and bounce direction, stepped once per frame end
`timescale 1ns/1ns

module spriteMotion
(
	input  logic                       iClk,
	input  logic                       rstN,
	input  logic [geomPkg::hWidth-1:0] iHdisplay,	// screen width
	input  logic [geomPkg::vWidth-1:0] iVdisplay,	// screen height
	input  logic                       iFe,			// frame end strobe
	spriteBoxIf.motion                 box
);

	logic [geomPkg::hWidth:0] leftX;	// left edge reg
	logic [geomPkg::vWidth:0] topY;		// top edge reg
	logic                     dirRight;	// 1: moving right
	logic                     dirUp;	// 1: moving up, top decreasing

	// x step candidates, one extra guard bit for the wall test
	logic [geomPkg::hWidth+1:0] xStep;		// left edge after a right step
	logic [geomPkg::hWidth+1:0] xStepEnd;	// one past right edge after that step
	logic                       xHitRight;
	logic                       xHitLeft;
	logic [geomPkg::hWidth:0]   xWallR;		// left edge with box on right wall
	logic [geomPkg::hWidth:0]   xNext;
	logic                       dirRightNext;

	// y step candidates
	logic [geomPkg::vWidth+1:0] yStep;		// top edge after a down step
	logic [geomPkg::vWidth+1:0] yStepEnd;	// one past bottom edge after that step
	logic                       yHitUnder;
	logic                       yHitTop;
	logic [geomPkg::vWidth:0]   yWallU;		// top edge with box on floor
	logic [geomPkg::vWidth:0]   yNext;
	logic                       dirUpNext;

	// --------------------------------------------------------------------------
	// wall detection
	// --------------------------------------------------------------------------
	assign xStep     = {1'b0, leftX} + (geomPkg::hWidth+2)'(geomPkg::stepX);
	assign xStepEnd  = xStep + (geomPkg::hWidth+2)'(geomPkg::spriteSize + 1);
	assign xHitRight = xStepEnd > {2'b00, iHdisplay};	// right edge past hdisplay-1
	assign xHitLeft  = leftX < (geomPkg::hWidth+1)'(geomPkg::stepX);	// would go below 0
	assign xWallR    = {1'b0, iHdisplay} - (geomPkg::hWidth+1)'(geomPkg::spriteSize + 1);

	assign yStep     = {1'b0, topY} + (geomPkg::vWidth+2)'(geomPkg::stepY);
	assign yStepEnd  = yStep + (geomPkg::vWidth+2)'(geomPkg::spriteSize + 1);
	assign yHitUnder = yStepEnd > {2'b00, iVdisplay};
	assign yHitTop   = topY < (geomPkg::vWidth+1)'(geomPkg::stepY);
	assign yWallU    = {1'b0, iVdisplay} - (geomPkg::vWidth+1)'(geomPkg::spriteSize + 1);

	// next x, clamp to the wall and turn around on a hit
	always_comb
	begin
		xNext        = leftX;
		dirRightNext = dirRight;
		if (dirRight)
		begin
			if (xHitRight)
			begin
				xNext        = xWallR;
				dirRightNext = 1'b0;
			end
			else
				xNext = xStep[geomPkg::hWidth:0];
		end
		else if (xHitLeft)
		begin
			xNext        = '0;			// touching left wall
			dirRightNext = 1'b1;
		end
		else
			xNext = leftX - (geomPkg::hWidth+1)'(geomPkg::stepX);
	end

	// next y, same rule
	always_comb
	begin
		yNext     = topY;
		dirUpNext = dirUp;
		if (!dirUp)
		begin
			if (yHitUnder)
			begin
				yNext     = yWallU;
				dirUpNext = 1'b1;
			end
			else
				yNext = yStep[geomPkg::vWidth:0];
		end
		else if (yHitTop)
		begin
			yNext     = '0;
			dirUpNext = 1'b0;
		end
		else
			yNext = topY - (geomPkg::vWidth+1)'(geomPkg::stepY);
	end

	// --------------------------------------------------------------------------
	// position regs, advance only on frame end
	// --------------------------------------------------------------------------
	always_ff @(posedge iClk or negedge rstN)
	begin
		if (!rstN)
		begin
			leftX    <= (geomPkg::hWidth+1)'(geomPkg::initX);
			topY     <= (geomPkg::vWidth+1)'(geomPkg::initY);
			dirRight <= 1'b1;
			dirUp    <= 1'b1;
		end
		else if (iFe)
		begin
			leftX    <= xNext;
			topY     <= yNext;
			dirRight <= dirRightNext;
			dirUp    <= dirUpNext;
		end
	end

	// far edges follow the fixed size
	assign box.leftX  = leftX;
	assign box.rightX = leftX + (geomPkg::hWidth+1)'(geomPkg::spriteSize);
	assign box.topY   = topY;
	assign box.underY = topY + (geomPkg::vWidth+1)'(geomPkg::spriteSize);

endmodule

//--- src/spriteBoxIf.sv
// spriteBoxIf: sprite box edges with motion source and box consumer modports
`timescale 1ns/1ns

interface spriteBoxIf;

	// edges carry one guard bit above the screen width
	logic [geomPkg::hWidth:0] leftX;	// left edge, inclusive
	logic [geomPkg::hWidth:0] rightX;	// right edge, inclusive
	logic [geomPkg::vWidth:0] topY;		// top edge, inclusive
	logic [geomPkg::vWidth:0] underY;	// bottom edge, inclusive

	// position keeper drives all four edges
	modport motion
	(
		output leftX,
		output rightX,
		output topY,
		output underY
	);

	// dot generator only looks at them
	modport box
	(
		input leftX,
		input rightX,
		input topY,
		input underY
	);

endinterface

//--- src/pixelPkg.sv
// pixelPkg: colour depth, pixel word type, checker colours and FIFO depth
package pixelPkg;

	// --------------------------------------------------------------------------
	// pixel word
	// --------------------------------------------------------------------------
	localparam int colorDepth = 16;		// rgb565

	typedef logic [colorDepth-1:0] pixelT;

	// --------------------------------------------------------------------------
	// background
	// --------------------------------------------------------------------------
	localparam pixelT bgColorA = 16'h18e3;	// dark grey tile
	localparam pixelT bgColorB = 16'h3a4b;	// slate tile

	// tile edge is 2**checkerShift pixels
	localparam int checkerShift = 4;

	// --------------------------------------------------------------------------
	// output FIFO
	// --------------------------------------------------------------------------
	localparam int fifoDepth     = 16;	// words
	localparam int fifoAddrWidth = 4;	// log2 of fifoDepth

endpackage

//--- src/geomPkg.sv
// geomPkg: screen coordinate widths, sprite size, motion steps and start position
package geomPkg;

	// --------------------------------------------------------------------------
	// coordinate widths
	// --------------------------------------------------------------------------
	localparam int hWidth = 11;		// horizontal coordinate bits
	localparam int vWidth = 11;		// vertical coordinate bits

	// --------------------------------------------------------------------------
	// sprite geometry
	// --------------------------------------------------------------------------
	// edge length minus one, box is 32 x 32
	localparam int spriteSize = 31;

	// per-frame motion
	localparam int stepX = 2;		// pixels per frame, horizontal
	localparam int stepY = 1;		// pixels per frame, vertical

	// box position out of reset
	localparam int initX = 0;		// left edge
	localparam int initY = 239;		// top edge

endpackage
